//--- hdl/decodeStage_settings.svh
`ifndef DECODE_STAGE_SETTINGS_SVH
`define DECODE_STAGE_SETTINGS_SVH

// pc held by the IF/ID register out of reset
// matches the MIPS boot vector in kseg1
`define DEC_RESET_PC  32'hbfc00000

// architectural general purpose registers
`define DEC_NUM_REGS  32

// bits needed to address one of them
`define DEC_REG_IDX_W 5

`endif

//--- hdl/decodePkg.sv
`include "decodeStage_settings.svh"

package decodePkg;

    // one instruction word, seen either as R-type or as I-type
    typedef union packed {
        struct packed {
            logic [5:0]                opcode;
            logic [`DEC_REG_IDX_W-1:0] rs;
            logic [`DEC_REG_IDX_W-1:0] rt;
            logic [`DEC_REG_IDX_W-1:0] rd;
            logic [4:0]                shamt;
            logic [5:0]                funct;
        } rFields;
        struct packed {
            logic [5:0]                opcode;
            logic [`DEC_REG_IDX_W-1:0] rs;
            logic [`DEC_REG_IDX_W-1:0] rt;
            logic [15:0]               imm16;
        } iFields;
    } instrWord_u;

    // major opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opJal     = 6'h03;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opSlti    = 6'h0a;
    localparam logic [5:0] opSltiu   = 6'h0b;
    localparam logic [5:0] opAndi    = 6'h0c;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opXori    = 6'h0e;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opCop0    = 6'h10;
    localparam logic [5:0] opLb      = 6'h20;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opLbu     = 6'h24;
    localparam logic [5:0] opSb      = 6'h28;
    localparam logic [5:0] opSw      = 6'h2b;

    // funct field of SPECIAL
    localparam logic [5:0] fnSll     = 6'h00;
    localparam logic [5:0] fnSrl     = 6'h02;
    localparam logic [5:0] fnSra     = 6'h03;
    localparam logic [5:0] fnJr      = 6'h08;
    localparam logic [5:0] fnSyscall = 6'h0c;
    localparam logic [5:0] fnBreak   = 6'h0d;
    localparam logic [5:0] fnMfhi    = 6'h10;
    localparam logic [5:0] fnMflo    = 6'h12;
    localparam logic [5:0] fnAddu    = 6'h21;
    localparam logic [5:0] fnSubu    = 6'h23;
    localparam logic [5:0] fnAnd     = 6'h24;
    localparam logic [5:0] fnOr      = 6'h25;
    localparam logic [5:0] fnXor     = 6'h26;
    localparam logic [5:0] fnSlt     = 6'h2a;
    localparam logic [5:0] fnSltu    = 6'h2b;

    localparam logic [`DEC_REG_IDX_W-1:0] cop0Mf = 5'h00;   // rs field of MFC0

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt,
        aluSltu, aluSll, aluSrl, aluSra, aluLui
    } aluOp_t;

    typedef enum logic [1:0] {loadNone, loadWord, loadByte, loadByteU} loadType_t;
    typedef enum logic [1:0] {storeNone, storeWord, storeByte} storeType_t;
    typedef enum logic [1:0] {wbAlu, wbLoad, wbPc8} wbSel_t;
    typedef enum logic [1:0] {dstRd, dstRt, dstRa} dstSel_t;
    typedef enum logic [1:0] {readRf, readHi, readLo, readCp0} regsReadSel_t;
    typedef enum logic [1:0] {extZero, extSign, extUpper} extOp_t;
    typedef enum logic {srcABusA, srcAShamt} aluSrcA_t;
    typedef enum logic {srcBBusB, srcBImm} aluSrcB_t;
    typedef enum logic [1:0] {branchNone, branchBeq, branchBne, branchJr} branchType_t;
    typedef enum logic [1:0] {
        exceptNone, exceptSyscall, exceptBreak, exceptReserved
    } exceptType_t;

endpackage

//--- hdl/decodeCtrlIf.sv
interface decodeCtrlIf import decodePkg::*; ();

    aluOp_t       aluOp;
    loadType_t    loadType;
    storeType_t   storeType;
    logic         regsWr;
    wbSel_t       wbSel;
    dstSel_t      dstSel;
    aluSrcA_t     aluSrcA;
    aluSrcB_t     aluSrcB;
    regsReadSel_t regsReadSel;
    extOp_t       extOp;
    branchType_t  branchType;
    exceptType_t  exceptType;
    logic         isImmJump;   // J or JAL
    logic [1:0]   rsrtRead;    // [1] rs read, [0] rt read

    modport decoder (
        output aluOp, loadType, storeType, regsWr, wbSel, dstSel,
               aluSrcA, aluSrcB, regsReadSel, extOp,
               branchType, exceptType, isImmJump, rsrtRead
    );

    modport consumer (
        input aluOp, loadType, storeType, regsWr, wbSel, dstSel,
              aluSrcA, aluSrcB, regsReadSel, extOp,
              branchType, exceptType, isImmJump, rsrtRead
    );

endinterface

//--- hdl/idPipeReg.sv
`include "decodeStage_settings.svh"

module idPipeReg import decodePkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        idFlush,
    input  logic        idWr,
    input  logic [31:0] ifInstr,
    input  logic [31:0] ifPc,
    output instrWord_u  idInstr,
    output logic [31:0] idPc
);

    // flush beats stall, idWr low just holds
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idInstr <= '0;
            idPc    <= `DEC_RESET_PC;
        end else if (idFlush) begin
            idInstr <= '0;          // bubble, pc stays put
        end else if (idWr) begin
            idInstr <= ifInstr;
            idPc    <= ifPc;
        end
    end

endmodule

//--- hdl/regFile.sv
`include "decodeStage_settings.svh"

module regFile (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      wbRegsWr,
    input  logic [`DEC_REG_IDX_W-1:0] wbDst,
    input  logic [31:0]               wbResult,
    input  logic [`DEC_REG_IDX_W-1:0] rs,
    input  logic [`DEC_REG_IDX_W-1:0] rt,
    output logic [31:0]               busA,
    output logic [31:0]               busB
);

    logic [31:0] regs [`DEC_NUM_REGS];
    logic        wbHit;    // write-back to a real register this cycle
    logic        fwdA;
    logic        fwdB;

    assign wbHit = wbRegsWr && (wbDst != '0);
    assign fwdA  = wbHit && (wbDst == rs);
    assign fwdB  = wbHit && (wbDst == rt);

    // entry 0 is cleared on reset and never written, so $zero reads zero
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `DEC_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wbHit) begin
            regs[wbDst] <= wbResult;
        end
    end

    // WB to ID bypass
    assign busA = fwdA ? wbResult : regs[rs];
    assign busB = fwdB ? wbResult : regs[rt];

endmodule

//--- hdl/controlDecoder.sv
module controlDecoder import decodePkg::*; (
    input  instrWord_u   instr,
    decodeCtrlIf.decoder ctrl
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr.iFields.opcode;
    assign funct  = instr.rFields.funct;

    always_comb begin
        // defaults describe a bubble
        ctrl.aluOp       = aluAdd;
        ctrl.loadType    = loadNone;
        ctrl.storeType   = storeNone;
        ctrl.regsWr      = 1'b0;
        ctrl.wbSel       = wbAlu;
        ctrl.dstSel      = dstRd;
        ctrl.aluSrcA     = srcABusA;
        ctrl.aluSrcB     = srcBBusB;
        ctrl.regsReadSel = readRf;
        ctrl.extOp       = extSign;
        ctrl.branchType  = branchNone;
        ctrl.exceptType  = exceptNone;
        ctrl.isImmJump   = 1'b0;
        ctrl.rsrtRead    = 2'b00;

        if (instr != '0) begin    // all-zero word stays a no-op
            case (opcode)
                opSpecial: begin
                    case (funct)
                        fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnSlt, fnSltu: begin
                            ctrl.regsWr   = 1'b1;
                            ctrl.rsrtRead = 2'b11;
                            case (funct)
                                fnSubu:  ctrl.aluOp = aluSub;
                                fnAnd:   ctrl.aluOp = aluAnd;
                                fnOr:    ctrl.aluOp = aluOr;
                                fnXor:   ctrl.aluOp = aluXor;
                                fnSlt:   ctrl.aluOp = aluSlt;
                                fnSltu:  ctrl.aluOp = aluSltu;
                                default: ctrl.aluOp = aluAdd;
                            endcase
                        end
                        fnSll, fnSrl, fnSra: begin
                            ctrl.regsWr   = 1'b1;
                            ctrl.aluSrcA  = srcAShamt;
                            ctrl.rsrtRead = 2'b01;
                            case (funct)
                                fnSrl:   ctrl.aluOp = aluSrl;
                                fnSra:   ctrl.aluOp = aluSra;
                                default: ctrl.aluOp = aluSll;
                            endcase
                        end
                        fnJr: begin
                            ctrl.branchType = branchJr;
                            ctrl.rsrtRead   = 2'b10;
                        end
                        fnMfhi, fnMflo: begin
                            // rs is $zero in a legal encoding, so OR passes busB
                            ctrl.regsWr      = 1'b1;
                            ctrl.aluOp       = aluOr;
                            ctrl.regsReadSel = (funct == fnMfhi) ? readHi : readLo;
                        end
                        fnSyscall: ctrl.exceptType = exceptSyscall;
                        fnBreak:   ctrl.exceptType = exceptBreak;
                        default:   ctrl.exceptType = exceptReserved;
                    endcase
                end
                opJ: ctrl.isImmJump = 1'b1;
                opJal: begin
                    ctrl.isImmJump = 1'b1;
                    ctrl.regsWr    = 1'b1;
                    ctrl.dstSel    = dstRa;
                    ctrl.wbSel     = wbPc8;     // link past the delay slot
                end
                opBeq, opBne: begin
                    ctrl.aluOp      = aluSub;
                    ctrl.rsrtRead   = 2'b11;
                    ctrl.branchType = (opcode == opBeq) ? branchBeq : branchBne;
                end
                opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
                    ctrl.regsWr   = 1'b1;
                    ctrl.dstSel   = dstRt;
                    ctrl.aluSrcB  = srcBImm;
                    ctrl.rsrtRead = 2'b10;
                    case (opcode)
                        opSlti:  ctrl.aluOp = aluSlt;
                        opSltiu: ctrl.aluOp = aluSltu;
                        opAndi:  ctrl.aluOp = aluAnd;
                        opOri:   ctrl.aluOp = aluOr;
                        opXori:  ctrl.aluOp = aluXor;
                        opLui:   ctrl.aluOp = aluLui;
                        default: ctrl.aluOp = aluAdd;
                    endcase
                    case (opcode)
                        opAndi, opOri, opXori: ctrl.extOp = extZero;
                        opLui:                 ctrl.extOp = extUpper;
                        default:               ctrl.extOp = extSign;
                    endcase
                end
                opCop0: begin
                    if (instr.rFields.rs == cop0Mf) begin    // MFC0 only
                        ctrl.regsWr      = 1'b1;
                        ctrl.dstSel      = dstRt;
                        ctrl.aluOp       = aluOr;
                        ctrl.regsReadSel = readCp0;
                    end else begin
                        ctrl.exceptType = exceptReserved;
                    end
                end
                opLw, opLb, opLbu: begin
                    ctrl.regsWr   = 1'b1;
                    ctrl.dstSel   = dstRt;
                    ctrl.wbSel    = wbLoad;
                    ctrl.aluSrcB  = srcBImm;
                    ctrl.rsrtRead = 2'b10;
                    case (opcode)
                        opLb:    ctrl.loadType = loadByte;
                        opLbu:   ctrl.loadType = loadByteU;
                        default: ctrl.loadType = loadWord;
                    endcase
                end
                opSw, opSb: begin
                    ctrl.aluSrcB   = srcBImm;
                    ctrl.rsrtRead  = 2'b11;       // base and store data
                    ctrl.storeType = (opcode == opSw) ? storeWord : storeByte;
                end
                default: ctrl.exceptType = exceptReserved;
            endcase
        end
    end

endmodule

//--- hdl/operandSelect.sv
module operandSelect import decodePkg::*; (
    decodeCtrlIf.consumer ctrl,
    input  logic [15:0]   imm16,
    input  logic [31:0]   rfBusB,
    input  logic [31:0]   hiBus,
    input  logic [31:0]   loBus,
    input  logic [31:0]   cp0Bus,
    output logic [31:0]   imm32,
    output logic [31:0]   busB
);

    // immediate extension
    always_comb begin
        case (ctrl.extOp)
            extZero:  imm32 = {16'h0000, imm16};
            extUpper: imm32 = {imm16, 16'h0000};    // LUI
            default:  imm32 = {{16{imm16[15]}}, imm16};
        endcase
    end

    // second operand source for the moves
    always_comb begin
        case (ctrl.regsReadSel)
            readHi:  busB = hiBus;
            readLo:  busB = loBus;
            readCp0: busB = cp0Bus;
            default: busB = rfBusB;
        endcase
    end

endmodule

//--- hdl/decodeStage.sv
`include "decodeStage_settings.svh"

module decodeStage import decodePkg::*; (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      idFlush,
    input  logic                      idWr,
    input  logic [31:0]               ifInstr,
    input  logic [31:0]               ifPc,
    input  logic [31:0]               wbResult,
    input  logic [`DEC_REG_IDX_W-1:0] wbDst,
    input  logic                      wbRegsWr,
    input  logic [31:0]               hiBus,
    input  logic [31:0]               loBus,
    input  logic [31:0]               cp0Bus,
    output logic [31:0]               idInstr,
    output logic [31:0]               idPc,
    output logic [`DEC_REG_IDX_W-1:0] idRs,
    output logic [`DEC_REG_IDX_W-1:0] idRt,
    output logic [`DEC_REG_IDX_W-1:0] idRd,
    output logic [31:0]               idImm32,
    output logic [31:0]               idBusA,
    output logic [31:0]               idBusB,
    output aluOp_t                    idAluOp,
    output loadType_t                 idLoadType,
    output storeType_t                idStoreType,
    output logic                      idRegsWr,
    output wbSel_t                    idWbSel,
    output dstSel_t                   idDstSel,
    output aluSrcA_t                  idAluSrcA,
    output aluSrcB_t                  idAluSrcB,
    output branchType_t               idBranchType,
    output exceptType_t               idExceptType,
    output logic                      idIsImmJump,   // to PC select
    output logic [1:0]                idRsrtRead     // to hazard unit
);

    instrWord_u  instr;
    logic [31:0] rfBusB;    // before the HI/LO/CP0 select
    decodeCtrlIf ctrlBus ();

    assign idInstr = instr;
    assign idRs    = instr.rFields.rs;
    assign idRt    = instr.rFields.rt;
    assign idRd    = instr.rFields.rd;

    idPipeReg u_idPipeReg (
        .clk     (clk),
        .rstN    (rstN),
        .idFlush (idFlush),
        .idWr    (idWr),
        .ifInstr (ifInstr),
        .ifPc    (ifPc),
        .idInstr (instr),
        .idPc    (idPc)
    );

    regFile u_regFile (
        .clk      (clk),
        .rstN     (rstN),
        .wbRegsWr (wbRegsWr),
        .wbDst    (wbDst),
        .wbResult (wbResult),
        .rs       (instr.rFields.rs),
        .rt       (instr.rFields.rt),
        .busA     (idBusA),
        .busB     (rfBusB)
    );

    controlDecoder u_controlDecoder (
        .instr (instr),
        .ctrl  (ctrlBus)
    );

    operandSelect u_operandSelect (
        .ctrl   (ctrlBus),
        .imm16  (instr.iFields.imm16),
        .rfBusB (rfBusB),
        .hiBus  (hiBus),
        .loBus  (loBus),
        .cp0Bus (cp0Bus),
        .imm32  (idImm32),
        .busB   (idBusB)
    );

    assign idAluOp      = ctrlBus.aluOp;
    assign idLoadType   = ctrlBus.loadType;
    assign idStoreType  = ctrlBus.storeType;
    assign idRegsWr     = ctrlBus.regsWr;
    assign idWbSel      = ctrlBus.wbSel;
    assign idDstSel     = ctrlBus.dstSel;
    assign idAluSrcA    = ctrlBus.aluSrcA;
    assign idAluSrcB    = ctrlBus.aluSrcB;
    assign idBranchType = ctrlBus.branchType;
    assign idExceptType = ctrlBus.exceptType;
    assign idIsImmJump  = ctrlBus.isImmJump;
    assign idRsrtRead   = ctrlBus.rsrtRead;

endmodule

//--- tb/decodeStageTb.sv
`include "decodeStage_settings.svh"

module decodeStageTb import decodePkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        logic [31:0] instr;
        logic        idWr;
        logic        idFlush;
        logic        wbWr;
        logic [4:0]  wbDst;
        logic [21:0] ctrl;      // packed expected control outputs
        logic [1:0]  immKind;   // 0 zero, 1 sign, 2 upper, 3 not checked
        logic [1:0]  bSrc;      // 0 regfile, 1 hi, 2 lo, 3 cp0
    } row_t;

    logic clk = 1'b0;
    logic rstN, idFlush, idWr, wbRegsWr;
    logic [31:0] ifInstr, ifPc, wbResult, hiBus, loBus, cp0Bus;
    logic [4:0]  wbDst;
    logic [31:0] idInstr, idPc, idImm32, idBusA, idBusB;
    logic [4:0]  idRs, idRt, idRd;
    aluOp_t      idAluOp;
    loadType_t   idLoadType;
    storeType_t  idStoreType;
    logic        idRegsWr;
    wbSel_t      idWbSel;
    dstSel_t     idDstSel;
    aluSrcA_t    idAluSrcA;
    aluSrcB_t    idAluSrcB;
    branchType_t idBranchType;
    exceptType_t idExceptType;
    logic        idIsImmJump;
    logic [1:0]  idRsrtRead;
    logic [21:0] ctrlSeen;

    row_t        rows [64];
    int          numRows = 0;
    logic [31:0] sb [32];         // register file mirror
    logic [31:0] expInstr;
    logic [31:0] expPc;
    integer      seed = 32'h2da10044;
    longint      limitNs = 0;

    always #20 clk = ~clk;

    assign ctrlSeen = {idAluOp, idLoadType, idStoreType, idRegsWr, idWbSel, idDstSel,
                       idAluSrcA, idAluSrcB, idBranchType, idExceptType, idIsImmJump,
                       idRsrtRead};

    decodeStage u_decodeStage (.*);

    function automatic logic [21:0] ctl(aluOp_t a, loadType_t l, storeType_t s, logic w,
                                        wbSel_t wb, dstSel_t d, aluSrcA_t sa, aluSrcB_t sb2,
                                        branchType_t b, exceptType_t e, logic j,
                                        logic [1:0] rr);
        return {a, l, s, w, wb, d, sa, sb2, b, e, j, rr};
    endfunction

    function automatic logic [21:0] rAlu(aluOp_t a, logic [1:0] rr, aluSrcA_t sa);
        return ctl(a, loadNone, storeNone, 1'b1, wbAlu, dstRd, sa, srcBBusB,
                   branchNone, exceptNone, 1'b0, rr);
    endfunction

    function automatic logic [21:0] iAlu(aluOp_t a);
        return ctl(a, loadNone, storeNone, 1'b1, wbAlu, dstRt, srcABusA, srcBImm,
                   branchNone, exceptNone, 1'b0, 2'b10);
    endfunction

    function automatic logic [21:0] ldCtl(loadType_t l);
        return ctl(aluAdd, l, storeNone, 1'b1, wbLoad, dstRt, srcABusA, srcBImm,
                   branchNone, exceptNone, 1'b0, 2'b10);
    endfunction

    function automatic logic [21:0] stCtl(storeType_t s);
        return ctl(aluAdd, loadNone, s, 1'b0, wbAlu, dstRd, srcABusA, srcBImm,
                   branchNone, exceptNone, 1'b0, 2'b11);
    endfunction

    function automatic logic [21:0] excCtl(exceptType_t e);
        return ctl(aluAdd, loadNone, storeNone, 1'b0, wbAlu, dstRd, srcABusA, srcBBusB,
                   branchNone, e, 1'b0, 2'b00);
    endfunction

    function automatic logic [31:0] rIns(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                         logic [4:0] sh, logic [5:0] fn);
        return {opSpecial, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iIns(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                         logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic addFlow(logic [31:0] instr, logic wr, logic fl, logic wbWr,
                           logic [4:0] dst, logic [21:0] ctrl, logic [1:0] immKind,
                           logic [1:0] bSrc);
        rows[numRows] = '{instr, wr, fl, wbWr, dst, ctrl, immKind, bSrc};
        numRows++;
    endtask

    task automatic addRow(logic [31:0] instr, logic [21:0] ctrl, logic [1:0] immKind,
                          logic [1:0] bSrc);
        addFlow(instr, 1'b1, 1'b0, 1'b0, 5'd0, ctrl, immKind, bSrc);
    endtask

    task automatic checkEq(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic applyRow(row_t r, logic [31:0] pc);
        logic [4:0]  rsI;
        logic [4:0]  rtI;
        logic        wbLive;
        logic [31:0] expA;
        logic [31:0] expB;
        logic [15:0] imm;
        @(posedge clk);
        #2;
        ifInstr  = r.instr;
        ifPc     = pc;
        idWr     = r.idWr;
        idFlush  = r.idFlush;
        wbRegsWr = 1'b0;
        if (r.idFlush) begin
            expInstr = '0;   // pc kept
        end else if (r.idWr) begin
            expInstr = r.instr;
            expPc    = pc;
        end
        @(posedge clk);
        #2;
        idWr     = 1'b0;
        idFlush  = 1'b0;
        wbRegsWr = r.wbWr;
        wbDst    = r.wbDst;
        wbResult = $random(seed);
        hiBus    = $random(seed);
        loBus    = $random(seed);
        cp0Bus   = $random(seed);
        #10;
        rsI    = expInstr[25:21];
        rtI    = expInstr[20:16];
        wbLive = r.wbWr && (r.wbDst != 5'd0);
        expA   = (wbLive && r.wbDst == rsI) ? wbResult : sb[rsI];
        case (r.bSrc)
            2'd1:    expB = hiBus;
            2'd2:    expB = loBus;
            2'd3:    expB = cp0Bus;
            default: expB = (wbLive && r.wbDst == rtI) ? wbResult : sb[rtI];
        endcase
        imm = expInstr[15:0];
        checkEq("idInstr", idInstr, expInstr);
        checkEq("idRs", idRs, rsI);
        checkEq("idRt", idRt, rtI);
        checkEq("idRd", idRd, expInstr[15:11]);
        checkEq("idPc", idPc, expPc);
        checkEq("control fields", {10'h0, ctrlSeen}, {10'h0, r.ctrl});
        checkEq("idBusA", idBusA, expA);
        checkEq("idBusB", idBusB, expB);
        case (r.immKind)
            2'd0:    checkEq("idImm32", idImm32, {16'h0000, imm});
            2'd1:    checkEq("idImm32", idImm32, {{16{imm[15]}}, imm});
            2'd2:    checkEq("idImm32", idImm32, {imm, 16'h0000});
            default: ;
        endcase
        if (wbLive) begin
            sb[r.wbDst] = wbResult;   // lands on the next edge
        end
    endtask

    task automatic buildTable();
        addRow(rIns(5'd1, 5'd2, 5'd3, 5'd0, fnAddu), rAlu(aluAdd, 2'b11, srcABusA), 2'd3, 2'd0);
        addRow(rIns(5'd4, 5'd5, 5'd6, 5'd0, fnSubu), rAlu(aluSub, 2'b11, srcABusA), 2'd3, 2'd0);
        addRow(rIns(5'd7, 5'd8, 5'd9, 5'd0, fnAnd), rAlu(aluAnd, 2'b11, srcABusA), 2'd3, 2'd0);
        addRow(rIns(5'd10, 5'd11, 5'd12, 5'd0, fnOr), rAlu(aluOr, 2'b11, srcABusA), 2'd3, 2'd0);
        addRow(rIns(5'd13, 5'd14, 5'd1, 5'd0, fnXor), rAlu(aluXor, 2'b11, srcABusA), 2'd3, 2'd0);
        addRow(rIns(5'd15, 5'd16, 5'd2, 5'd0, fnSlt), rAlu(aluSlt, 2'b11, srcABusA), 2'd3, 2'd0);
        addRow(rIns(5'd17, 5'd18, 5'd3, 5'd0, fnSltu), rAlu(aluSltu, 2'b11, srcABusA), 2'd3, 2'd0);
        addRow(rIns(5'd0, 5'd19, 5'd4, 5'd5, fnSll), rAlu(aluSll, 2'b01, srcAShamt), 2'd3, 2'd0);
        addRow(rIns(5'd0, 5'd20, 5'd5, 5'd9, fnSrl), rAlu(aluSrl, 2'b01, srcAShamt), 2'd3, 2'd0);
        addRow(rIns(5'd0, 5'd21, 5'd6, 5'd31, fnSra), rAlu(aluSra, 2'b01, srcAShamt), 2'd3, 2'd0);
        addRow(rIns(5'd0, 5'd22, 5'd7, 5'd0, fnAddu), rAlu(aluAdd, 2'b11, srcABusA), 2'd3, 2'd0);
        addRow(iIns(opAddiu, 5'd23, 5'd8, 16'h8001), iAlu(aluAdd), 2'd1, 2'd0);
        addRow(iIns(opSlti, 5'd24, 5'd9, 16'h7ff0), iAlu(aluSlt), 2'd1, 2'd0);
        addRow(iIns(opSltiu, 5'd25, 5'd10, 16'hff00), iAlu(aluSltu), 2'd1, 2'd0);
        addRow(iIns(opAndi, 5'd26, 5'd11, 16'hf0f0), iAlu(aluAnd), 2'd0, 2'd0);
        addRow(iIns(opOri, 5'd27, 5'd12, 16'h8421), iAlu(aluOr), 2'd0, 2'd0);
        // hold: idWr low keeps the ORI
        addFlow(iIns(opXori, 5'd1, 5'd1, 16'h1111), 1'b0, 1'b0, 1'b0, 5'd0,
                iAlu(aluOr), 2'd0, 2'd0);
        addRow(iIns(opXori, 5'd28, 5'd13, 16'hc3c3), iAlu(aluXor), 2'd0, 2'd0);
        addRow(iIns(opLui, 5'd0, 5'd14, 16'h1234), iAlu(aluLui), 2'd2, 2'd0);
        addRow(iIns(opLw, 5'd29, 5'd15, 16'hfffc), ldCtl(loadWord), 2'd1, 2'd0);
        addRow(iIns(opLb, 5'd30, 5'd16, 16'h0003), ldCtl(loadByte), 2'd1, 2'd0);
        addRow(iIns(opLbu, 5'd31, 5'd17, 16'h8002), ldCtl(loadByteU), 2'd1, 2'd0);
        addRow(iIns(opSw, 5'd1, 5'd18, 16'hff80), stCtl(storeWord), 2'd1, 2'd0);
        addRow(iIns(opSb, 5'd2, 5'd19, 16'h0010), stCtl(storeByte), 2'd1, 2'd0);
        addRow(iIns(opBeq, 5'd3, 5'd20, 16'h8000), ctl(aluSub, loadNone, storeNone, 1'b0,
               wbAlu, dstRd, srcABusA, srcBBusB, branchBeq, exceptNone, 1'b0, 2'b11),
               2'd1, 2'd0);
        addRow(iIns(opBne, 5'd4, 5'd21, 16'h0040), ctl(aluSub, loadNone, storeNone, 1'b0,
               wbAlu, dstRd, srcABusA, srcBBusB, branchBne, exceptNone, 1'b0, 2'b11),
               2'd1, 2'd0);
        addRow({opJ, 26'h0123456}, ctl(aluAdd, loadNone, storeNone, 1'b0, wbAlu, dstRd,
               srcABusA, srcBBusB, branchNone, exceptNone, 1'b1, 2'b00), 2'd3, 2'd0);
        addRow({opJal, 26'h3abcdef}, ctl(aluAdd, loadNone, storeNone, 1'b1, wbPc8, dstRa,
               srcABusA, srcBBusB, branchNone, exceptNone, 1'b1, 2'b00), 2'd3, 2'd0);
        addRow(rIns(5'd31, 5'd0, 5'd0, 5'd0, fnJr), ctl(aluAdd, loadNone, storeNone, 1'b0,
               wbAlu, dstRd, srcABusA, srcBBusB, branchJr, exceptNone, 1'b0, 2'b10),
               2'd3, 2'd0);
        addRow(rIns(5'd0, 5'd0, 5'd5, 5'd0, fnMfhi), rAlu(aluOr, 2'b00, srcABusA), 2'd3, 2'd1);
        addRow(rIns(5'd0, 5'd0, 5'd6, 5'd0, fnMflo), rAlu(aluOr, 2'b00, srcABusA), 2'd3, 2'd2);
        addRow({opCop0, 5'd0, 5'd7, 5'd12, 11'h0}, ctl(aluOr, loadNone, storeNone, 1'b1,
               wbAlu, dstRt, srcABusA, srcBBusB, branchNone, exceptNone, 1'b0, 2'b00),
               2'd3, 2'd3);
        addRow(rIns(5'd0, 5'd0, 5'd0, 5'd0, fnSyscall), excCtl(exceptSyscall), 2'd3, 2'd0);
        addRow(rIns(5'd0, 5'd0, 5'd0, 5'd0, fnBreak), excCtl(exceptBreak), 2'd3, 2'd0);
        addRow({6'h3f, 26'h0000001}, excCtl(exceptReserved), 2'd3, 2'd0);
        addRow(rIns(5'd1, 5'd2, 5'd3, 5'd0, 6'h3f), excCtl(exceptReserved), 2'd3, 2'd0);
        addRow({opCop0, 5'd4, 5'd7, 5'd12, 11'h0}, excCtl(exceptReserved), 2'd3, 2'd0);
        // bypass on rs, on rt, then stored values with wbRegsWr low
        addFlow(rIns(5'd7, 5'd8, 5'd9, 5'd0, fnAddu), 1'b1, 1'b0, 1'b1, 5'd7,
                rAlu(aluAdd, 2'b11, srcABusA), 2'd3, 2'd0);
        addFlow(rIns(5'd7, 5'd8, 5'd9, 5'd0, fnAddu), 1'b1, 1'b0, 1'b1, 5'd8,
                rAlu(aluAdd, 2'b11, srcABusA), 2'd3, 2'd0);
        addFlow(rIns(5'd7, 5'd8, 5'd9, 5'd0, fnAddu), 1'b1, 1'b0, 1'b0, 5'd7,
                rAlu(aluAdd, 2'b11, srcABusA), 2'd3, 2'd0);
        addFlow(rIns(5'd0, 5'd0, 5'd9, 5'd0, fnAddu), 1'b1, 1'b0, 1'b1, 5'd0,
                rAlu(aluAdd, 2'b11, srcABusA), 2'd3, 2'd0);
        // flush wins over idWr
        addFlow(rIns(5'd1, 5'd2, 5'd3, 5'd0, fnAddu), 1'b1, 1'b1, 1'b0, 5'd0,
                22'h0, 2'd1, 2'd0);
    endtask

    initial begin
        wait (limitNs != 0);
        #(limitNs);
        $display("Done: errors found");
        $fatal(1, "watchdog expired before the tests finished");
    end

    initial begin
        rstN     = 1'b0;
        idFlush  = 1'b0;
        idWr     = 1'b0;
        ifInstr  = '0;
        ifPc     = '0;
        wbResult = '0;
        wbDst    = '0;
        wbRegsWr = 1'b0;
        hiBus    = '0;
        loBus    = '0;
        cp0Bus   = '0;
        for (int i = 0; i < 32; i++) begin
            sb[i] = '0;
        end
        buildTable();
        limitNs  = (2 * numRows + 32 + 16 + 64) * 40;

        repeat (15) @(posedge clk);
        #10;
        checkEq("idPc", idPc, `DEC_RESET_PC);
        checkEq("idInstr", idInstr, 32'h0);
        checkEq("control fields", {10'h0, ctrlSeen}, 32'h0);
        @(posedge clk);
        #2;
        rstN     = 1'b1;
        expInstr = '0;
        expPc    = `DEC_RESET_PC;

        // fill every register through write-back, $zero included
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            #2;
            wbRegsWr = 1'b1;
            wbDst    = i[4:0];
            wbResult = $random(seed);
            if (i != 0) begin
                sb[i] = wbResult;
            end
        end

        for (int n = 0; n < numRows; n++) begin
            applyRow(rows[n], 32'h00400000 + 32'(n * 4));
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+hdl
hdl/decodePkg.sv
hdl/decodeCtrlIf.sv
hdl/idPipeReg.sv
hdl/regFile.sv
hdl/controlDecoder.sv
hdl/operandSelect.sv
hdl/decodeStage.sv
tb/decodeStageTb.sv

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f vlog.f \
    --top-module decodeStageTb \
    -o decodeStageSim

./obj_dir/decodeStageSim
